// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
TOP        ?= ob_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+verification
hw/ob_pkg.sv
hw/ob_fifo.sv
hw/ob_table.sv
hw/ob_cntrl.sv
hw/ob_top.sv
verification/ob_tb.sv

// File: hw/ob_cntrl.sv
// Matching controller; one command at a time, a full table is rejected at once
module ob_cntrl
  import ob_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_vld,
  input  cmd_t      cmd_head,
  output logic      cmd_pop,
  input  logic      rsp_full,
  output logic      rsp_push,
  output rsp_t      rsp_data,
  input  logic      bid_head_vld,
  input  entry_t    bid_head,
  input  logic      bid_full,
  output logic      bid_insert,
  output entry_t    bid_insert_entry,
  output logic      bid_pop,
  output logic      bid_update,
  output quantity_t bid_update_qty,
  input  logic      ask_head_vld,
  input  entry_t    ask_head,
  input  logic      ask_full,
  output logic      ask_insert,
  output entry_t    ask_insert_entry,
  output logic      ask_pop,
  output logic      ask_update,
  output quantity_t ask_update_qty
);

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    ISSUE_QRY = 2'd1,
    EXECUTE   = 2'd2
  } state_t;

  state_t    state;
  state_t    state_nxt;
  entry_t    new_entry;

  // Head compare, registered in ISSUE_QRY
  logic      cmp_cross;
  logic      cmp_bid_done;
  logic      cmp_ask_done;
  quantity_t cmp_qty;
  quantity_t cmp_rem;
  logic      bid_more;
  logic      ask_more;

  // Same entry offered to both tables, only one gets insert
  assign new_entry.uid      = cmd_head.uid;
  assign new_entry.quantity = cmd_head.quantity;
  assign new_entry.price    = cmd_head.price;
  assign bid_insert_entry   = new_entry;
  assign ask_insert_entry   = new_entry;

  assign bid_more = (bid_head.quantity > ask_head.quantity);
  assign ask_more = (ask_head.quantity > bid_head.quantity);

  // Surviving head gets the remainder
  assign bid_update_qty = cmp_rem;
  assign ask_update_qty = cmp_rem;

  always_comb begin
    state_nxt  = state;
    cmd_pop    = 1'b0;
    rsp_push   = 1'b0;
    rsp_data   = '0;
    bid_insert = 1'b0;
    ask_insert = 1'b0;
    bid_pop    = 1'b0;
    ask_pop    = 1'b0;
    bid_update = 1'b0;
    ask_update = 1'b0;
    case (state)
      IDLE: begin
        // Pop and answer in the same cycle
        if (cmd_vld && !rsp_full) begin
          cmd_pop      = 1'b1;
          rsp_push     = 1'b1;
          rsp_data.uid = cmd_head.uid;
          case (cmd_head.opcode)
            OP_BUY: begin
              if (bid_full) begin
                rsp_data.status = S_REJECT;
              end else begin
                bid_insert      = 1'b1;
                rsp_data.status = S_OKAY;
                state_nxt       = ISSUE_QRY;
              end
            end
            OP_SELL: begin
              if (ask_full) begin
                rsp_data.status = S_REJECT;
              end else begin
                ask_insert      = 1'b1;
                rsp_data.status = S_OKAY;
                state_nxt       = ISSUE_QRY;
              end
            end
            OP_QRY_BIDASK: begin
              rsp_data.status = (bid_head_vld && ask_head_vld) ? S_OKAY : S_BAD;
              // Empty side reads as zero rather than a stale slot
              rsp_data.result.qry.bid_price = bid_head_vld ? bid_head.price : '0;
              rsp_data.result.qry.ask_price = ask_head_vld ? ask_head.price : '0;
            end
            default: begin
              rsp_data.status = S_OKAY;
            end
          endcase
        end
      end
      // Tables have settled, compare is latched this cycle
      ISSUE_QRY: begin
        state_nxt = EXECUTE;
      end
      EXECUTE: begin
        if (!cmp_cross) begin
          state_nxt = IDLE;
        end else if (!rsp_full) begin
          rsp_push                          = 1'b1;
          rsp_data.uid                      = TRADE_UID;
          rsp_data.status                   = S_TRADE;
          rsp_data.result.trade.body.bid_uid  = bid_head.uid;
          rsp_data.result.trade.body.ask_uid  = ask_head.uid;
          rsp_data.result.trade.body.quantity = cmp_qty;
          bid_pop    = cmp_bid_done;
          ask_pop    = cmp_ask_done;
          bid_update = !cmp_bid_done;
          ask_update = !cmp_ask_done;
          // Heads may still cross after this trade
          state_nxt  = ISSUE_QRY;
        end
        // Else stall on a full response queue, tables untouched
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      cmp_cross <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == ISSUE_QRY) begin
        cmp_cross <= bid_head_vld && ask_head_vld && (bid_head.price >= ask_head.price);
      end
    end
  end

  // Smaller side is consumed, both on equal quantity
  always_ff @(posedge clk) begin
    if (state == ISSUE_QRY) begin
      cmp_bid_done <= !bid_more;
      cmp_ask_done <= !ask_more;
      cmp_qty      <= bid_more ? ask_head.quantity : bid_head.quantity;
      cmp_rem      <= bid_more ? (bid_head.quantity - ask_head.quantity)
                               : (ask_head.quantity - bid_head.quantity);
    end
  end

endmodule

// File: hw/ob_fifo.sv
// Synchronous FIFO; caller must not push when full nor pop when empty, no internal checks
module ob_fifo
  import ob_pkg::*;
#(
  parameter int  DEPTH     = 4,
  parameter type payload_t = cmd_t
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage carries no reset
  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;

  // Wrap explicitly so DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop leaves occupancy unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head is valid whenever not empty
  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

endmodule

// File: hw/ob_pkg.sv
// Shared order-book types; plain binary prices, trade results zero-extended into the union
package ob_pkg;

  // Field widths
  localparam int UID_W   = 8;
  localparam int PRICE_W = 16;
  localparam int QTY_W   = 12;

  typedef logic [UID_W-1:0]   uid_t;
  typedef logic [PRICE_W-1:0] price_t;
  typedef logic [QTY_W-1:0]   quantity_t;

  // Command codes
  typedef enum logic [1:0] {
    OP_NOP        = 2'd0,
    OP_BUY        = 2'd1,
    OP_SELL       = 2'd2,
    OP_QRY_BIDASK = 2'd3
  } opcode_t;

  // Response status codes
  typedef enum logic [2:0] {
    S_OKAY   = 3'd0,
    S_BAD    = 3'd1,
    S_REJECT = 3'd2,
    S_TRADE  = 3'd3
  } status_t;

  // Incoming command, 38 bits
  typedef struct packed {
    opcode_t   opcode;
    uid_t      uid;
    quantity_t quantity;
    price_t    price;
  } cmd_t;

  // One resting order in a table slot, 36 bits
  typedef struct packed {
    uid_t      uid;
    quantity_t quantity;
    price_t    price;
  } entry_t;

  // Trade report, 28 bits
  typedef struct packed {
    uid_t      bid_uid;
    uid_t      ask_uid;
    quantity_t quantity;
  } trade_t;

  // Trade padded up to the union width, pad always zero
  typedef struct packed {
    logic [3:0] pad;
    trade_t     body;
  } trade_ext_t;

  // Head prices for a bid/ask query, 32 bits
  typedef struct packed {
    price_t bid_price;
    price_t ask_price;
  } qry_t;

  typedef union packed {
    trade_ext_t trade;
    qry_t       qry;
  } result_t;

  // Outgoing response, 43 bits
  typedef struct packed {
    uid_t    uid;
    status_t status;
    result_t result;
  } rsp_t;

  // Trades have no originating command
  localparam uid_t TRADE_UID = '1;

endpackage

// File: hw/ob_table.sv
// Sorted order table, one op per cycle; insert when full or pop when empty is not guarded here
module ob_table
  import ob_pkg::*;
#(
  parameter int TABLE_DEPTH = 4,
  parameter bit IS_BID      = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      insert,
  input  entry_t    insert_entry,
  input  logic      pop,
  input  logic      update,
  input  quantity_t update_qty,
  output logic      head_vld,
  output entry_t    head,
  output logic      full
);

  // Slot 0 is the best order; valid slots are always contiguous from 0
  entry_t                 slots     [TABLE_DEPTH];
  entry_t                 slots_nxt [TABLE_DEPTH];
  logic [TABLE_DEPTH-1:0] vld;
  logic [TABLE_DEPTH-1:0] vld_nxt;
  logic [TABLE_DEPTH-1:0] beats;

  // New entry outranks slot i
  // Strict compare keeps arrival order among equal prices
  always_comb begin
    for (int i = 0; i < TABLE_DEPTH; i++) begin
      if (!vld[i]) begin
        beats[i] = 1'b1;
      end else if (IS_BID) begin
        beats[i] = (insert_entry.price > slots[i].price);
      end else begin
        beats[i] = (insert_entry.price < slots[i].price);
      end
    end
  end

  always_comb begin
    slots_nxt = slots;
    vld_nxt   = vld;
    if (insert) begin
      // Slot 0 only ever takes the new entry
      if (beats[0]) begin
        slots_nxt[0] = insert_entry;
        vld_nxt[0]   = 1'b1;
      end
      for (int i = 1; i < TABLE_DEPTH; i++) begin
        if (beats[i-1]) begin
          // Worse slots move down one place
          slots_nxt[i] = slots[i-1];
          vld_nxt[i]   = vld[i-1];
        end else if (beats[i]) begin
          // First slot the new entry beats
          slots_nxt[i] = insert_entry;
          vld_nxt[i]   = 1'b1;
        end
      end
    end else if (pop) begin
      // Everything moves up, last slot empties
      for (int i = 0; i < TABLE_DEPTH - 1; i++) begin
        slots_nxt[i] = slots[i+1];
      end
      vld_nxt = vld >> 1;
    end else if (update) begin
      // Partial fill of the head
      slots_nxt[0].quantity = update_qty;
    end
  end

  always_ff @(posedge clk) begin
    slots <= slots_nxt;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else begin
      vld <= vld_nxt;
    end
  end

  assign head_vld = vld[0];
  assign head     = slots[0];
  // Contiguous valids, so last slot in use means full
  assign full     = vld[TABLE_DEPTH-1];

endmodule

// File: hw/ob_top.sv
// Order-book top; source pushes only while cmd_full low, sink pops only while rsp_empty low
module ob_top
  import ob_pkg::*;
#(
  parameter int CMD_DEPTH   = 4,
  parameter int RSP_DEPTH   = 8,
  parameter int TABLE_DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic cmd_push,
  input  cmd_t cmd,
  output logic cmd_full,
  input  logic rsp_pop,
  output rsp_t rsp,
  output logic rsp_empty
);

  // Command queue to controller
  logic      cmd_empty;
  logic      cmd_pop;
  cmd_t      cmd_head;

  // Controller to response queue
  logic      rsp_push;
  rsp_t      rsp_data;
  logic      rsp_full;

  // Bid side
  logic      bid_head_vld;
  entry_t    bid_head;
  logic      bid_full;
  logic      bid_insert;
  entry_t    bid_insert_entry;
  logic      bid_pop;
  logic      bid_update;
  quantity_t bid_update_qty;

  // Ask side
  logic      ask_head_vld;
  entry_t    ask_head;
  logic      ask_full;
  logic      ask_insert;
  entry_t    ask_insert_entry;
  logic      ask_pop;
  logic      ask_update;
  quantity_t ask_update_qty;

  ob_fifo #(.DEPTH(CMD_DEPTH), .payload_t(cmd_t)) u_cmd_fifo (
    .clk(clk), .rst_n(rst_n), .push(cmd_push), .push_data(cmd), .pop(cmd_pop),
    .head(cmd_head), .empty(cmd_empty), .full(cmd_full)
  );

  ob_fifo #(.DEPTH(RSP_DEPTH), .payload_t(rsp_t)) u_rsp_fifo (
    .clk(clk), .rst_n(rst_n), .push(rsp_push), .push_data(rsp_data), .pop(rsp_pop),
    .head(rsp), .empty(rsp_empty), .full(rsp_full)
  );

  // Bids kept highest price first
  ob_table #(.TABLE_DEPTH(TABLE_DEPTH), .IS_BID(1'b1)) u_bid_table (
    .clk(clk), .rst_n(rst_n), .insert(bid_insert), .insert_entry(bid_insert_entry),
    .pop(bid_pop), .update(bid_update), .update_qty(bid_update_qty),
    .head_vld(bid_head_vld), .head(bid_head), .full(bid_full)
  );

  // Asks kept lowest price first
  ob_table #(.TABLE_DEPTH(TABLE_DEPTH), .IS_BID(1'b0)) u_ask_table (
    .clk(clk), .rst_n(rst_n), .insert(ask_insert), .insert_entry(ask_insert_entry),
    .pop(ask_pop), .update(ask_update), .update_qty(ask_update_qty),
    .head_vld(ask_head_vld), .head(ask_head), .full(ask_full)
  );

  ob_cntrl u_cntrl (
    .clk(clk), .rst_n(rst_n),
    .cmd_vld(~cmd_empty), .cmd_head(cmd_head), .cmd_pop(cmd_pop),
    .rsp_full(rsp_full), .rsp_push(rsp_push), .rsp_data(rsp_data),
    .bid_head_vld(bid_head_vld), .bid_head(bid_head), .bid_full(bid_full),
    .bid_insert(bid_insert), .bid_insert_entry(bid_insert_entry), .bid_pop(bid_pop),
    .bid_update(bid_update), .bid_update_qty(bid_update_qty),
    .ask_head_vld(ask_head_vld), .ask_head(ask_head), .ask_full(ask_full),
    .ask_insert(ask_insert), .ask_insert_entry(ask_insert_entry), .ask_pop(ask_pop),
    .ask_update(ask_update), .ask_update_qty(ask_update_qty)
  );

endmodule

// File: verification/ob_tb_model.svh
// Reference order book; BOOK_SLOTS must match the DUT TABLE_DEPTH, prices compare unsigned

  localparam int BOOK_SLOTS = 4;
  // Compare kinds kept with each expected response
  localparam int KIND_STATUS = 0;
  localparam int KIND_TRADE  = 1;
  localparam int KIND_QRY    = 2;

  // Resting orders, best first
  entry_t bid_book[$];
  entry_t ask_book[$];

  function automatic void expect_rsp(input rsp_t r, input int kind, input string name);
    exp_q.push_back(r);
    exp_kind_q.push_back(kind);
    exp_name_q.push_back(name);
  endfunction

  // First slot the new price strictly beats, so equal prices keep arrival order
  function automatic int slot_for(input entry_t book[$], input price_t p, input bit is_bid);
    for (int i = 0; i < book.size(); i++) begin
      if (is_bid ? (p > book[i].price) : (p < book[i].price)) begin
        return i;
      end
    end
    return book.size();
  endfunction

  // Trade the heads until they stop crossing
  function automatic void match_books(input string name);
    rsp_t      t;
    entry_t    b;
    entry_t    a;
    quantity_t q;
    while (bid_book.size() != 0 && ask_book.size() != 0 &&
           bid_book[0].price >= ask_book[0].price) begin
      b = bid_book.pop_front();
      a = ask_book.pop_front();
      q = (b.quantity < a.quantity) ? b.quantity : a.quantity;
      t = '0;
      t.uid    = TRADE_UID;
      t.status = S_TRADE;
      t.result.trade.body.bid_uid  = b.uid;
      t.result.trade.body.ask_uid  = a.uid;
      t.result.trade.body.quantity = q;
      expect_rsp(t, KIND_TRADE, name);
      b.quantity = b.quantity - q;
      a.quantity = a.quantity - q;
      // Survivor keeps its place at the head
      if (b.quantity != 0) begin
        bid_book.push_front(b);
      end
      if (a.quantity != 0) begin
        ask_book.push_front(a);
      end
    end
  endfunction

  function automatic void ob_model(input cmd_t c, input string name);
    rsp_t   r;
    entry_t e;
    bit     is_buy;
    r = '0;
    r.uid      = c.uid;
    r.status   = S_OKAY;
    e.uid      = c.uid;
    e.quantity = c.quantity;
    e.price    = c.price;
    is_buy     = (c.opcode == OP_BUY);
    case (c.opcode)
      OP_NOP: begin
        expect_rsp(r, KIND_STATUS, name);
      end
      OP_QRY_BIDASK: begin
        // Missing side reads as zero
        if (bid_book.size() == 0 || ask_book.size() == 0) begin
          r.status = S_BAD;
        end
        if (bid_book.size() != 0) begin
          r.result.qry.bid_price = bid_book[0].price;
        end
        if (ask_book.size() != 0) begin
          r.result.qry.ask_price = ask_book[0].price;
        end
        expect_rsp(r, KIND_QRY, name);
      end
      default: begin
        if ((is_buy ? bid_book.size() : ask_book.size()) >= BOOK_SLOTS) begin
          r.status = S_REJECT;
          expect_rsp(r, KIND_STATUS, name);
        end else begin
          expect_rsp(r, KIND_STATUS, name);
          if (is_buy) begin
            bid_book.insert(slot_for(bid_book, c.price, 1'b1), e);
          end else begin
            ask_book.insert(slot_for(ask_book, c.price, 1'b0), e);
          end
          match_books(name);
        end
      end
    endcase
  endfunction

  task automatic check_status_rsp(input string name, input rsp_t exp, input rsp_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s status: expected uid %0d st %0d res %h, actual uid %0d st %0d res %h",
               name, exp.uid, exp.status, exp.result, act.uid, act.status, act.result);
    end
  endtask

  // Trade uids shown as bid/ask, raw is the whole actual response
  task automatic check_trade_rsp(input string name, input rsp_t exp, input rsp_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s trade: expected %0d/%0d qty %0d, actual %0d/%0d qty %0d, raw %h",
               name, exp.result.trade.body.bid_uid, exp.result.trade.body.ask_uid,
               exp.result.trade.body.quantity, act.result.trade.body.bid_uid,
               act.result.trade.body.ask_uid, act.result.trade.body.quantity, act);
    end
  endtask

  task automatic check_qry_rsp(input string name, input rsp_t exp, input rsp_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s query: expected st %0d bid %0d ask %0d, actual st %0d bid %0d ask %0d",
               name, exp.status, exp.result.qry.bid_price, exp.result.qry.ask_price,
               act.status, act.result.qry.bid_price, act.result.qry.ask_price);
    end
  endtask

// File: verification/ob_tb.sv
// Self-checking order-book testbench; assumes default ob_top depths, model slots track TABLE_DEPTH
module ob_tb
  import ob_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD    = 100;
  localparam int DIRECTED_CMDS = 24;
  localparam int RANDOM_CMDS   = 200;
  localparam int PAT_LEN       = 4096;

  logic clk;
  logic rst_n;
  logic cmd_push;
  cmd_t cmd;
  logic cmd_full;
  logic rsp_pop = 1'b0;
  rsp_t rsp;
  logic rsp_empty;

  // Expected responses in DUT order, with owning test and compare kind
  rsp_t  exp_q[$];
  int    exp_kind_q[$];
  string exp_name_q[$];
  int    mismatch_cnt = 0;
  int    unexpected_cnt = 0;
  int    missing_cnt;
  string cur_test;
  int    seed;
  // Sink pop pattern for the back-pressure phase
  bit    pop_pat [PAT_LEN];
  bit    bp_on;
  int    bp_cycle = 0;

  `include "ob_tb_model.svh"

  ob_top ob_top_inst (
    .clk(clk), .rst_n(rst_n), .cmd_push(cmd_push), .cmd(cmd), .cmd_full(cmd_full),
    .rsp_pop(rsp_pop), .rsp(rsp), .rsp_empty(rsp_empty)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // One command per call, model updated at the push
  task automatic send_cmd(input opcode_t op, input uid_t uid, input quantity_t qty,
                          input price_t price);
    cmd_t c;
    c.opcode   = op;
    c.uid      = uid;
    c.quantity = qty;
    c.price    = price;
    @(negedge clk);
    while (cmd_full) begin
      @(negedge clk);
    end
    cmd      = c;
    cmd_push = 1'b1;
    ob_model(c, cur_test);
    @(negedge clk);
    cmd_push = 1'b0;
  endtask

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
  endtask

  // Compare process, pops on the falling edge where rsp is stable
  always @(negedge clk) begin
    rsp_t  want;
    int    kind;
    string name;
    bit    allow;
    rsp_pop = 1'b0;
    if (bp_on) begin
      bp_cycle++;
    end
    allow = !bp_on || bp_cycle >= PAT_LEN || pop_pat[bp_cycle];
    if (rst_n && !rsp_empty && allow) begin
      rsp_pop = 1'b1;
      if (exp_q.size() == 0) begin
        unexpected_cnt++;
        $display("Response %h arrived during %s while none was expected", rsp, cur_test);
      end else begin
        want = exp_q.pop_front();
        kind = exp_kind_q.pop_front();
        name = exp_name_q.pop_front();
        if (kind == KIND_TRADE) begin
          check_trade_rsp(name, want, rsp);
        end else if (kind == KIND_QRY) begin
          check_qry_rsp(name, want, rsp);
        end else begin
          check_status_rsp(name, want, rsp);
        end
      end
    end
  end

  initial begin
    int r;
    int len;
    int idx;
    bit level;
    clk      = 1'b0;
    rst_n    = 1'b0;
    cmd_push = 1'b0;
    cmd      = '0;
    bp_on    = 1'b0;
    seed     = 32'hbd285ef0;
    cur_test = "reset";
    // Alternating pop and stall stretches of 1 to 16 cycles
    idx   = 0;
    level = 1'b1;
    while (idx < PAT_LEN) begin
      len = 1 + ($random(seed) & 15);
      for (int k = 0; k < len && idx < PAT_LEN; k++) begin
        pop_pat[idx] = level;
        idx++;
      end
      level = !level;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    cur_test = "nop_query";
    send_cmd(OP_NOP, 8'd1, 12'd0, 16'd0);
    send_cmd(OP_QRY_BIDASK, 8'd5, 12'd0, 16'd0);
    send_cmd(OP_BUY, 8'd2, 12'd10, 16'd100);
    send_cmd(OP_SELL, 8'd3, 12'd10, 16'd110);
    send_cmd(OP_QRY_BIDASK, 8'd6, 12'd0, 16'd0);
    drain(200);

    // Clears the resting ask, then an equal-size SELL takes the last bid
    cur_test = "full_cross";
    send_cmd(OP_BUY, 8'd10, 12'd10, 16'd110);
    send_cmd(OP_SELL, 8'd11, 12'd10, 16'd95);
    send_cmd(OP_QRY_BIDASK, 8'd12, 12'd0, 16'd0);
    drain(200);

    cur_test = "partial_fill";
    send_cmd(OP_SELL, 8'd20, 12'd5, 16'd105);
    send_cmd(OP_SELL, 8'd21, 12'd4, 16'd103);
    send_cmd(OP_SELL, 8'd22, 12'd6, 16'd104);
    send_cmd(OP_BUY, 8'd23, 12'd20, 16'd105);
    send_cmd(OP_SELL, 8'd24, 12'd1, 16'd200);
    send_cmd(OP_QRY_BIDASK, 8'd25, 12'd0, 16'd0);
    drain(200);

    // Two equal bids at 90 behind a better one at 95
    cur_test = "priority";
    send_cmd(OP_BUY, 8'd30, 12'd3, 16'd90);
    send_cmd(OP_BUY, 8'd31, 12'd3, 16'd90);
    send_cmd(OP_BUY, 8'd32, 12'd3, 16'd95);
    send_cmd(OP_SELL, 8'd33, 12'd20, 16'd80);
    drain(200);

    cur_test = "full_reject";
    send_cmd(OP_BUY, 8'd40, 12'd2, 16'd50);
    send_cmd(OP_BUY, 8'd41, 12'd2, 16'd60);
    send_cmd(OP_BUY, 8'd42, 12'd2, 16'd70);
    send_cmd(OP_BUY, 8'd43, 12'd2, 16'd55);
    send_cmd(OP_BUY, 8'd44, 12'd2, 16'd75);
    send_cmd(OP_QRY_BIDASK, 8'd45, 12'd0, 16'd0);
    drain(200);

    // Prices 48 to 111 reach the resting bids and asks, so both sides trade
    cur_test = "backpressure";
    bp_on = 1'b1;
    for (int i = 0; i < RANDOM_CMDS; i++) begin
      r = $random(seed);
      send_cmd(opcode_t'(r[1:0]), uid_t'(50 + i % 200), quantity_t'(1 + r[7:4]),
               price_t'(48 + r[13:8]));
    end
    bp_on = 1'b0;
    drain(4000);
    // Room for any stray response to show up
    repeat (20) @(negedge clk);

    missing_cnt = exp_q.size();
    if (missing_cnt != 0) begin
      $display("%0d expected responses never arrived, first owed to %s",
               missing_cnt, exp_name_q[0]);
    end
    $display("Errors: %0d mismatches, %0d unexpected responses, %0d missing responses",
             mismatch_cnt, unexpected_cnt, missing_cnt);
    if (mismatch_cnt == 0 && unexpected_cnt == 0 && missing_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog, 60 cycles per command plus reset
  initial begin
    #((DIRECTED_CMDS + RANDOM_CMDS) * 60 * CLK_PERIOD + 10 * CLK_PERIOD);
    $display("Timeout in %s: the DUT stopped answering, %0d responses still owed",
             cur_test, exp_q.size());
    $display("Errors: %0d mismatches, %0d unexpected responses", mismatch_cnt, unexpected_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
